/* armIsaPkg.sv */
/*
 * ARM instruction set definitions for the kept subset
 * Field layouts, condition codes, opcodes and register numbers
 */
package armIsaPkg;

   localparam int wordWidth = 32;

   // Condition field encodings
   localparam logic [3:0] condEq = 4'b0000;   // Z set
   localparam logic [3:0] condNe = 4'b0001;
   localparam logic [3:0] condCs = 4'b0010;   // Carry set, unsigned >=
   localparam logic [3:0] condCc = 4'b0011;
   localparam logic [3:0] condMi = 4'b0100;
   localparam logic [3:0] condPl = 4'b0101;
   localparam logic [3:0] condVs = 4'b0110;
   localparam logic [3:0] condVc = 4'b0111;
   localparam logic [3:0] condHi = 4'b1000;   // C set and Z clear
   localparam logic [3:0] condLs = 4'b1001;
   localparam logic [3:0] condGe = 4'b1010;   // N equals V
   localparam logic [3:0] condLt = 4'b1011;
   localparam logic [3:0] condGt = 4'b1100;
   localparam logic [3:0] condLe = 4'b1101;
   localparam logic [3:0] condAl = 4'b1110;

   // Major op field, bits 27:26
   localparam logic [1:0] opDataProc = 2'b00;
   localparam logic [1:0] opMemory   = 2'b01;
   localparam logic [1:0] opBranch   = 2'b10;

   // Kept data-processing opcodes
   localparam logic [3:0] dpAnd = 4'b0000;
   localparam logic [3:0] dpSub = 4'b0010;
   localparam logic [3:0] dpAdd = 4'b0100;
   localparam logic [3:0] dpOrr = 4'b1100;

   localparam logic [3:0] pcRegIndex   = 4'd15;
   localparam logic [3:0] linkRegIndex = 4'd14;

   typedef struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        immFlag;    // Operand2 is imm8
      logic [3:0]  opcode;
      logic        s;          // Update flags
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] operand2;   // imm8 or rm in low bits
   } dataProcFields;

   typedef struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic        immFlag;
      logic [3:0]  puBW;       // Indexing bits, fixed at offset mode
      logic        l;          // Load when set
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] imm12;
   } memoryFields;

   typedef struct packed {
      logic [3:0]  cond;
      logic [1:0]  op;
      logic [1:0]  funct;      // Bit 0 is link
      logic [23:0] imm24;      // Signed word offset
   } branchFields;

   typedef union packed {
      dataProcFields dataProc;
      memoryFields   memory;
      branchFields   branch;
   } armInstr;

endpackage

/* armCtrlPkg.sv */
/*
 * Internal control encodings of the core
 * ALU codes, immediate selects and flag word layout
 */
package armCtrlPkg;

   // ALU control, bit 0 selects subtract on the adder
   localparam logic [1:0] aluAdd = 2'b00;
   localparam logic [1:0] aluSub = 2'b01;
   localparam logic [1:0] aluAnd = 2'b10;
   localparam logic [1:0] aluOrr = 2'b11;

   // Immediate extension select
   localparam logic [1:0] immByte   = 2'b00;   // Zero-extended imm8
   localparam logic [1:0] immOffset = 2'b01;   // Zero-extended imm12
   localparam logic [1:0] immBranch = 2'b10;   // Sign-extended imm24, word scaled

   // Bit positions in the 4-bit flag word
   localparam int flagN = 3;
   localparam int flagZ = 2;
   localparam int flagC = 1;
   localparam int flagV = 0;

endpackage

/* regFile.sv */
/*
 * Register file, R0 to R14 in storage
 * Two combinational reads, one clocked write, R15 reads as PC+8
 */
`timescale 1ns/1ps

module regFile
   import armIsaPkg::*;
(
   input  logic                 clk,
   input  logic                 writeEnable,
   input  logic [3:0]           readAddr1,
   input  logic [3:0]           readAddr2,
   input  logic [3:0]           writeAddr,
   input  logic [wordWidth-1:0] writeData,
   input  logic [wordWidth-1:0] pcPlus8,
   output logic [wordWidth-1:0] readData1,
   output logic [wordWidth-1:0] readData2
);

   logic [wordWidth-1:0] regs [0:14];   // No R15 entry

   always_ff @(posedge clk)
   begin
      if (writeEnable)
         regs[writeAddr] <= writeData;
   end

   assign readData1 = (readAddr1 == pcRegIndex) ? pcPlus8 : regs[readAddr1];
   assign readData2 = (readAddr2 == pcRegIndex) ? pcPlus8 : regs[readAddr2];

   // R15 writes must have been turned into PC loads upstream
   assert property (@(posedge clk) writeEnable |-> writeAddr != pcRegIndex);

endmodule

/* armAlu.sv */
/*
 * ALU for ADD, SUB, AND, ORR
 * One adder serves both arithmetic codes and supplies C and V
 */
`timescale 1ns/1ps

module armAlu
   import armIsaPkg::*;
   import armCtrlPkg::*;
(
   input  logic [wordWidth-1:0] srcA,
   input  logic [wordWidth-1:0] srcB,
   input  logic [1:0]           aluControl,
   output logic [wordWidth-1:0] result,
   output logic [3:0]           aluFlags
);

   logic                 isSub;
   logic                 isArith;
   logic [wordWidth-1:0] addB;   // srcB, inverted for subtract
   logic [wordWidth:0]   sum;    // Top bit is carry out

   assign isSub   = (aluControl == aluSub);
   assign isArith = (aluControl == aluAdd) || isSub;
   assign addB    = isSub ? ~srcB : srcB;
   assign sum     = {1'b0, srcA} + {1'b0, addB} + {{wordWidth{1'b0}}, isSub};   // A + ~B + 1

   always_comb
   begin
      case (aluControl)
         aluAnd:  result = srcA & srcB;
         aluOrr:  result = srcA | srcB;
         default: result = sum[wordWidth-1:0];
      endcase
   end

   always_comb
   begin
      aluFlags        = '0;
      aluFlags[flagN] = result[wordWidth-1];
      aluFlags[flagZ] = (result == '0);
      aluFlags[flagC] = isArith & sum[wordWidth];   // Carry, ARM style no-borrow on SUB
      // Operands agree in sign but the sum does not
      aluFlags[flagV] = isArith & (srcA[wordWidth-1] == addB[wordWidth-1]) &
                        (sum[wordWidth-1] != srcA[wordWidth-1]);
   end

endmodule

/* armDecoder.sv */
/*
 * Instruction decoder
 * Produces datapath selects and write requests before condition checks
 */
`timescale 1ns/1ps

module armDecoder
   import armIsaPkg::*;
   import armCtrlPkg::*;
(
   input  armInstr    instr,
   output logic [2:0] regSrc,        // {link write, rd as read 2, PC as read 1}
   output logic [1:0] immSrc,
   output logic       aluSrc,
   output logic       memToReg,
   output logic [1:0] aluControl,
   output logic [1:0] flagWriteReq,  // {N/Z, C/V}
   output logic       regWriteReq,
   output logic       memWriteReq,
   output logic       memAccess,
   output logic       pcSrcReq
);

   logic       supportedDp;   // Opcode is one of the kept four
   logic [1:0] dpAluControl;
   logic       writesRd;      // Result goes to the rd field
   logic       isBranch;
   logic       rdIsPc;

   // ALU decoder
   always_comb
   begin
      supportedDp = 1'b1;
      case (instr.dataProc.opcode)
         dpAnd:   dpAluControl = aluAnd;
         dpSub:   dpAluControl = aluSub;
         dpAdd:   dpAluControl = aluAdd;
         dpOrr:   dpAluControl = aluOrr;
         default:
         begin
            dpAluControl = aluAdd;
            supportedDp  = 1'b0;   // Dropped opcode, acts as no-op
         end
      endcase
   end

   // Main decoder
   always_comb
   begin
      regSrc       = 3'b000;   // Defaults describe an instruction doing nothing
      immSrc       = immByte;
      aluSrc       = 1'b0;
      memToReg     = 1'b0;
      aluControl   = aluAdd;
      flagWriteReq = 2'b00;
      writesRd     = 1'b0;
      memWriteReq  = 1'b0;
      memAccess    = 1'b0;
      isBranch     = 1'b0;
      case (instr.dataProc.op)
         opDataProc:
         begin
            aluSrc          = instr.dataProc.immFlag;
            aluControl      = dpAluControl;
            writesRd        = supportedDp;
            flagWriteReq[1] = instr.dataProc.s & supportedDp;
            // Carry and overflow only from the adder
            flagWriteReq[0] = instr.dataProc.s & supportedDp &
                              ((dpAluControl == aluAdd) || (dpAluControl == aluSub));
         end
         opMemory:
         begin
            regSrc[1]   = ~instr.memory.l;   // STR reads rd as store data
            immSrc      = immOffset;
            aluSrc      = 1'b1;
            memToReg    = instr.memory.l;
            writesRd    = instr.memory.l;
            memWriteReq = ~instr.memory.l;
            memAccess   = 1'b1;
         end
         opBranch:
         begin
            regSrc   = {instr.branch.funct[0], 1'b0, 1'b1};   // PC+8 base, R14 on BL
            immSrc   = immBranch;
            aluSrc   = 1'b1;
            isBranch = 1'b1;
         end
         default: ;   // op 11 unsupported
      endcase
   end

   assign rdIsPc = (instr.dataProc.rd == pcRegIndex);

   // A write to R15 becomes a PC load, never a register file write
   assign regWriteReq = (writesRd & ~rdIsPc) | (isBranch & instr.branch.funct[0]);
   assign pcSrcReq    = isBranch | (writesRd & rdIsPc);

endmodule

/* condUnit.sv */
/*
 * Condition unit
 * Holds NZCV, evaluates the condition field and gates all writes
 */
`timescale 1ns/1ps

module condUnit
   import armIsaPkg::*;
   import armCtrlPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic [3:0] cond,
   input  logic [3:0] aluFlags,
   input  logic [1:0] flagWriteReq,
   input  logic       regWriteReq,
   input  logic       memWriteReq,
   input  logic       memAccess,
   input  logic       pcSrcReq,
   input  logic       pcReady,
   output logic       regWrite,
   output logic       memWrite,
   output logic       memStrobe,
   output logic       pcSrc
);

   logic [3:0] flags;       // Stored NZCV
   logic       condEx;      // Condition passed
   logic       commit;      // Passed and not stalled
   logic [1:0] flagWrite;
   logic       ge;

   assign ge = (flags[flagN] == flags[flagV]);

   always_comb
   begin
      case (cond)
         condEq:  condEx = flags[flagZ];
         condNe:  condEx = ~flags[flagZ];
         condCs:  condEx = flags[flagC];
         condCc:  condEx = ~flags[flagC];
         condMi:  condEx = flags[flagN];
         condPl:  condEx = ~flags[flagN];
         condVs:  condEx = flags[flagV];
         condVc:  condEx = ~flags[flagV];
         condHi:  condEx = flags[flagC] & ~flags[flagZ];
         condLs:  condEx = ~flags[flagC] | flags[flagZ];
         condGe:  condEx = ge;
         condLt:  condEx = ~ge;
         condGt:  condEx = ~flags[flagZ] & ge;
         condLe:  condEx = flags[flagZ] | ~ge;
         condAl:  condEx = 1'b1;
         default: condEx = 1'b0;   // 1111 never executes
      endcase
   end

   assign commit    = condEx & pcReady;
   assign flagWrite = flagWriteReq & {2{commit}};
   assign regWrite  = regWriteReq & commit;
   assign memWrite  = memWriteReq & commit;
   assign memStrobe = memAccess & condEx;   // Strobe follows the access, not the stall
   assign pcSrc     = pcSrcReq & condEx;    // PC enable itself waits on pcReady

   // N/Z and C/V pairs load independently
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         flags <= '0;
      else
      begin
         if (flagWrite[1])
         begin
            flags[flagN] <= aluFlags[flagN];
            flags[flagZ] <= aluFlags[flagZ];
         end
         if (flagWrite[0])
         begin
            flags[flagC] <= aluFlags[flagC];
            flags[flagV] <= aluFlags[flagV];
         end
      end
   end

   // Program must not hold the reserved condition
   assert property (@(posedge clk) disable iff (reset) pcReady |-> cond != 4'b1111);

endmodule

/* armDatapath.sv */
/*
 * Datapath of the single-cycle core
 * PC register, immediate extension, operand and result muxing
 */
`timescale 1ns/1ps

module armDatapath
   import armIsaPkg::*;
   import armCtrlPkg::*;
#(
   parameter logic [31:0] resetPc = 32'h0
)
(
   input  logic                 clk,
   input  logic                 reset,
   input  armInstr              instr,
   input  logic [2:0]           regSrc,
   input  logic [1:0]           immSrc,
   input  logic                 aluSrc,
   input  logic                 memToReg,
   input  logic [1:0]           aluControl,
   input  logic                 regWrite,
   input  logic                 pcSrc,
   input  logic                 pcReady,
   input  logic [wordWidth-1:0] readData,
   output logic [wordWidth-1:0] pc,
   output logic [3:0]           aluFlags,
   output logic [wordWidth-1:0] aluResult,
   output logic [wordWidth-1:0] writeData
);

   logic [wordWidth-1:0] pcPlus4;
   logic [wordWidth-1:0] pcPlus8;
   logic [wordWidth-1:0] pcNext;
   logic [wordWidth-1:0] extImm;
   logic [wordWidth-1:0] srcA;
   logic [wordWidth-1:0] srcB;
   logic [wordWidth-1:0] result;          // ALU or load data
   logic [wordWidth-1:0] regWriteData;
   logic [3:0]           readAddr1;
   logic [3:0]           readAddr2;
   logic [3:0]           writeAddr;

   assign pcPlus4 = pc + 32'd4;
   assign pcPlus8 = pcPlus4 + 32'd4;     // Value seen on R15 reads
   assign pcNext  = pcSrc ? result : pcPlus4;

   // PC advances only on committing edges
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pc <= resetPc;
      else if (pcReady)
         pc <= pcNext;
   end

   always_comb
   begin
      case (immSrc)
         immByte:   extImm = {24'b0, instr.dataProc.operand2[7:0]};
         immOffset: extImm = {20'b0, instr.memory.imm12};
         immBranch: extImm = {{6{instr.branch.imm24[23]}}, instr.branch.imm24, 2'b00};
         default:   extImm = '0;
      endcase
   end

   // Register addressing
   assign readAddr1 = regSrc[0] ? pcRegIndex : instr.dataProc.rn;   // Branch base is PC+8
   assign readAddr2 = regSrc[1] ? instr.dataProc.rd : instr.dataProc.operand2[3:0];
   assign writeAddr = regSrc[2] ? linkRegIndex : instr.dataProc.rd;
   assign regWriteData = regSrc[2] ? pcPlus4 : result;                // BL return address

   regFile regFile0 (
      .clk        (clk),
      .writeEnable(regWrite),
      .readAddr1  (readAddr1),
      .readAddr2  (readAddr2),
      .writeAddr  (writeAddr),
      .writeData  (regWriteData),
      .pcPlus8    (pcPlus8),
      .readData1  (srcA),
      .readData2  (writeData)
   );

   assign srcB = aluSrc ? extImm : writeData;

   armAlu armAlu0 (
      .srcA      (srcA),
      .srcB      (srcB),
      .aluControl(aluControl),
      .result    (aluResult),
      .aluFlags  (aluFlags)
   );

   assign result = memToReg ? readData : aluResult;

   // Branch offsets are word scaled, loads to PC must be aligned too
   assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

/* armCore.sv */
/*
 * Single-cycle core for the ARM subset
 * Decoder, condition unit and datapath joined to the memory ports
 */
`timescale 1ns/1ps

module armCore #(
   parameter logic [31:0] resetPc = 32'h0
)
(
   input  logic        clk,
   input  logic        reset,
   output logic [31:0] pc,
   input  logic [31:0] instr,
   input  logic        pcReady,      // Low stalls the whole core
   output logic [31:0] aluResult,    // Data address
   output logic [31:0] writeData,
   output logic        memWrite,
   output logic        memStrobe,
   input  logic [31:0] readData
);

   logic [2:0] regSrc;
   logic [1:0] immSrc;
   logic       aluSrc;
   logic       memToReg;
   logic [1:0] aluControl;
   logic [1:0] flagWriteReq;
   logic       regWriteReq;
   logic       memWriteReq;
   logic       memAccess;
   logic       pcSrcReq;
   logic       regWrite;      // Gated by condition and pcReady
   logic       pcSrc;
   logic [3:0] aluFlags;

   armDecoder armDecoder0 (
      .instr       (instr),
      .regSrc      (regSrc),
      .immSrc      (immSrc),
      .aluSrc      (aluSrc),
      .memToReg    (memToReg),
      .aluControl  (aluControl),
      .flagWriteReq(flagWriteReq),
      .regWriteReq (regWriteReq),
      .memWriteReq (memWriteReq),
      .memAccess   (memAccess),
      .pcSrcReq    (pcSrcReq)
   );

   condUnit condUnit0 (
      .clk         (clk),
      .reset       (reset),
      .cond        (instr[31:28]),
      .aluFlags    (aluFlags),
      .flagWriteReq(flagWriteReq),
      .regWriteReq (regWriteReq),
      .memWriteReq (memWriteReq),
      .memAccess   (memAccess),
      .pcSrcReq    (pcSrcReq),
      .pcReady     (pcReady),
      .regWrite    (regWrite),
      .memWrite    (memWrite),
      .memStrobe   (memStrobe),
      .pcSrc       (pcSrc)
   );

   armDatapath #(
      .resetPc(resetPc)
   ) armDatapath0 (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .regSrc    (regSrc),
      .immSrc    (immSrc),
      .aluSrc    (aluSrc),
      .memToReg  (memToReg),
      .aluControl(aluControl),
      .regWrite  (regWrite),
      .pcSrc     (pcSrc),
      .pcReady   (pcReady),
      .readData  (readData),
      .pc        (pc),
      .aluFlags  (aluFlags),
      .aluResult (aluResult),
      .writeData (writeData)
   );

endmodule

/* tbArmModel.svh */
/*
 * Instruction-level reference model of the ARM subset
 * Own registers, flags and data memory, one instruction per step
 */
`ifndef TB_ARM_MODEL_SVH
`define TB_ARM_MODEL_SVH

logic [31:0] mReg [0:14];
logic [31:0] mMem [0:1023];   // Word addressed like the testbench memory
logic [31:0] mPc;
logic [3:0]  mFlags;          // N Z C V from bit 3 down
logic        mStore;          // Last step stored a word
logic        mAccess;         // Last step touched memory
logic [31:0] mStoreAddr;
logic [31:0] mStoreData;

// R15 reads two instructions ahead
function automatic logic [31:0] modelRead(input logic [3:0] r);
   return (r == 4'd15) ? mPc + 32'd8 : mReg[r];
endfunction

function automatic logic condHolds(input logic [3:0] c);
   logic n;
   logic z;
   logic cf;
   logic v;
   {n, z, cf, v} = mFlags;
   case (c)
      4'h0:    return z;
      4'h1:    return !z;
      4'h2:    return cf;
      4'h3:    return !cf;
      4'h4:    return n;
      4'h5:    return !n;
      4'h6:    return v;
      4'h7:    return !v;
      4'h8:    return cf && !z;           // Unsigned higher
      4'h9:    return !cf || z;
      4'hA:    return n == v;             // Signed greater or equal
      4'hB:    return n != v;
      4'hC:    return !z && (n == v);
      4'hD:    return z || (n != v);
      4'hE:    return 1'b1;
      default: return 1'b0;
   endcase
endfunction

// Executes one instruction, leaves the store it made in mStore*
function automatic void modelStep(input logic [31:0] ins);
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] res;
   logic [32:0] wide;
   logic [31:0] nextPc;
   logic        known;
   logic        arith;
   logic        pass;
   pass    = condHolds(ins[31:28]);
   nextPc  = mPc + 32'd4;
   mStore  = 1'b0;
   mAccess = 1'b0;
   case (ins[27:26])
      2'b00:
      begin
         a     = modelRead(ins[19:16]);
         b     = ins[25] ? {24'b0, ins[7:0]} : modelRead(ins[3:0]);
         res   = '0;
         wide  = '0;
         known = 1'b1;
         arith = 1'b0;
         case (ins[24:21])
            4'h0: res = a & b;
            4'hC: res = a | b;
            4'h4:
            begin
               wide  = {1'b0, a} + {1'b0, b};
               arith = 1'b1;
            end
            4'h2:
            begin
               wide  = {1'b0, a} + {1'b0, ~b} + 33'd1;   // Carry set means no borrow
               arith = 1'b1;
            end
            default: known = 1'b0;   // Anything else writes nothing
         endcase
         if (arith)
            res = wide[31:0];
         if (pass && known)
         begin
            if (ins[15:12] == 4'd15)
               nextPc = res;
            else
               mReg[ins[15:12]] = res;
            if (ins[20])
            begin
               mFlags[3] = res[31];
               mFlags[2] = (res == 32'd0);
               if (arith)
               begin
                  mFlags[1] = wide[32];
                  // Sign of the effective second operand flips on SUB
                  mFlags[0] = (a[31] == (b[31] ^ (ins[24:21] == 4'h2))) && (res[31] != a[31]);
               end
            end
         end
      end
      2'b01:
         if (pass)
         begin
            a       = modelRead(ins[19:16]) + {20'b0, ins[11:0]};
            mAccess = 1'b1;
            if (ins[20])
            begin
               if (ins[15:12] == 4'd15)
                  nextPc = mMem[a[11:2]];
               else
                  mReg[ins[15:12]] = mMem[a[11:2]];
            end
            else
            begin
               mStore        = 1'b1;
               mStoreAddr    = a;
               mStoreData    = modelRead(ins[15:12]);
               mMem[a[11:2]] = mStoreData;
            end
         end
      2'b10:
         if (pass)
         begin
            if (ins[24])
               mReg[14] = mPc + 32'd4;   // Link
            nextPc = mPc + 32'd8 + {{6{ins[23]}}, ins[23:0], 2'b00};
         end
      default: ;
   endcase
   mPc = nextPc;
endfunction

`endif

/* tbArmCore.sv */
/*
 * Testbench for the ARM subset core
 * Runs a fixed program against an instruction-level model under random stalls
 */
`timescale 1ns/1ps

module tbArmCore
   import armIsaPkg::*;
();

   localparam logic [31:0] resetPc = 32'h0;
   localparam int clkPeriod = 100;
   localparam int watchdogMargin = 40;   // Cycles on top of four per instruction

   logic        clk;
   logic        reset;
   logic        pcReady;
   logic [31:0] pc;
   logic [31:0] instr;
   logic [31:0] aluResult;
   logic [31:0] writeData;
   logic [31:0] readData;
   logic        memWrite;
   logic        memStrobe;

   logic [31:0] imem [0:255];
   logic [31:0] dmem [0:1023];

   int          progLen;
   int          dataStart;       // Section starts, for error names
   int          condStart;
   int          branchStart;
   logic [31:0] haltAddr;
   int          errors = 0;
   int          checks = 0;
   bit          running = 1'b0;
   bit          done = 1'b0;
   bit          stalledPrev = 1'b0;
   logic [31:0] lastPc;

   `include "tbArmModel.svh"

   armCore #(
      .resetPc(resetPc)
   ) dut0 (
      .clk      (clk),
      .reset    (reset),
      .pc       (pc),
      .instr    (instr),
      .pcReady  (pcReady),
      .aluResult(aluResult),
      .writeData(writeData),
      .memWrite (memWrite),
      .memStrobe(memStrobe),
      .readData (readData)
   );

   assign instr    = imem[pc[9:2]];          // Combinational fetch
   assign readData = dmem[aluResult[11:2]];

   always @(posedge clk)
   begin
      if (memWrite)
         dmem[aluResult[11:2]] <= writeData;
   end

   initial
   begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   function automatic logic [31:0] encDp(input logic [3:0] cond, input logic imm,
                                         input logic [3:0] opcode, input logic s,
                                         input logic [3:0] rn, input logic [3:0] rd,
                                         input logic [11:0] op2);
      return {cond, 2'b00, imm, opcode, s, rn, rd, op2};
   endfunction

   // Offset addressing, P and U set
   function automatic logic [31:0] encMem(input logic [3:0] cond, input logic load,
                                          input logic [3:0] rn, input logic [3:0] rd,
                                          input logic [11:0] imm12);
      return {cond, 2'b01, 1'b0, 4'b1100, load, rn, rd, imm12};
   endfunction

   function automatic logic [31:0] encBr(input logic [3:0] cond, input logic link,
                                         input int from, input int to);
      logic [23:0] off;
      off = 24'(to - from - 2);   // Target is PC+8 plus offset words
      return {cond, 2'b10, 1'b1, link, off};
   endfunction

   function automatic void emit(input logic [31:0] word);
      imem[progLen] = word;
      progLen++;
   endfunction

   function automatic string sectionName(input logic [31:0] addr);
      int idx;
      idx = int'(addr[9:2]);
      if (idx < dataStart)
         return "memory";
      else if (idx < condStart)
         return "data processing";
      else if (idx < branchStart)
         return "conditions";
      return "branches";
   endfunction

   task automatic compareWord(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual === expected)
      else
      begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic expectTrue(input logic ok, input string what);
      checks++;
      assert (ok === 1'b1)
      else
      begin
         errors++;
         $display("%s", what);
      end
   endtask

   task automatic buildProgram();
      logic [3:0]  dpOps [0:3];
      logic [31:0] setters [0:5];
      logic [11:0] op2;
      logic        immForm;
      int          j;
      dpOps = '{dpAdd, dpSub, dpAnd, dpOrr};
      for (int i = 0; i < 256; i++)
         imem[i] = {condAl, 2'b11, 26'(i)};   // Unsupported op, does nothing
      progLen = 0;
      emit(encDp(condAl, 1'b0, dpSub, 1'b0, 4'd15, 4'd0, 12'd15));   // R0 = 0
      emit(encMem(condAl, 1'b1, 4'd0, 4'd1, 12'h010));
      emit(encMem(condAl, 1'b1, 4'd0, 4'd2, 12'h124));
      emit(encMem(condAl, 1'b1, 4'd0, 4'd3, 12'h7fc));
      emit(encMem(condAl, 1'b1, 4'd0, 4'd4, 12'h3a8));
      emit(encMem(condAl, 1'b1, 4'd0, 4'd8, 12'h200));   // Max positive
      emit(encMem(condAl, 1'b1, 4'd0, 4'd9, 12'h204));   // Min negative
      emit(encMem(condAl, 1'b1, 4'd0, 4'd11, 12'hffc));
      emit(encMem(condAl, 1'b0, 4'd0, 4'd11, 12'h880));
      emit(encMem(condAl, 1'b0, 4'd0, 4'd1, 12'h884));
      dataStart = progLen;
      for (int k = 0; k < 8; k++)
      begin
         immForm = (k >= 4);
         op2 = immForm ? {4'b0, 8'(k * 67 + 29)} : 12'(4 - k);
         emit(encDp(condAl, immForm, dpOps[k % 4], 1'b0, 4'(k % 4 + 1), 4'd5, op2));
         emit(encMem(condAl, 1'b0, 4'd0, 4'd5, 12'(12'h800 + k * 4)));
      end
      emit(encDp(condAl, 1'b1, 4'b0001, 1'b1, 4'd1, 4'd5, 12'd3));   // EOR, dropped
      emit(encMem(condAl, 1'b0, 4'd0, 4'd5, 12'h820));
      emit({condAl, 2'b11, 26'h3ffffff});
      condStart = progLen;
      setters[0] = encDp(condAl, 1'b0, dpSub, 1'b1, 4'd1, 4'd7, 12'd2);
      setters[1] = encDp(condAl, 1'b0, dpSub, 1'b1, 4'd1, 4'd7, 12'd1);   // Zero, carry
      setters[2] = encDp(condAl, 1'b1, dpAdd, 1'b1, 4'd8, 4'd7, 12'd1);   // Overflow
      setters[3] = encDp(condAl, 1'b1, dpSub, 1'b1, 4'd9, 4'd7, 12'd1);
      setters[4] = encDp(condAl, 1'b0, dpAnd, 1'b1, 4'd9, 4'd7, 12'd9);   // C, V kept
      setters[5] = encDp(condAl, 1'b0, dpOrr, 1'b1, 4'd0, 4'd7, 12'd0);
      for (int r = 0; r < 6; r++)
      begin
         emit(setters[r]);
         for (int c = 0; c < 15; c++)
            emit(encMem(4'(c), 1'b0, 4'd0, 4'd1, 12'(12'h900 + r * 64 + c * 4)));
      end
      branchStart = progLen;
      emit(encDp(condAl, 1'b1, dpAdd, 1'b0, 4'd15, 4'd10, 12'd0));   // R10 = PC+8
      emit(encMem(condAl, 1'b0, 4'd0, 4'd10, 12'hb00));
      j = progLen;
      emit(encBr(condAl, 1'b0, j, j + 4));                            // Forward
      emit(encMem(condAl, 1'b0, 4'd0, 4'd14, 12'hb04));                // Subroutine
      emit(encDp(condAl, 1'b1, dpAdd, 1'b0, 4'd14, 4'd15, 12'd0));    // Return via R15
      emit(encMem(condAl, 1'b0, 4'd0, 4'd1, 12'hb08));                 // Never reached
      emit(encBr(condAl, 1'b1, j + 4, j + 1));                         // BL backward
      emit(encBr(condAl, 1'b0, j + 5, j + 8));
      emit(encMem(condAl, 1'b0, 4'd0, 4'd1, 12'hb0c));
      emit(encBr(condAl, 1'b0, j + 7, j + 9));
      emit(encBr(condAl, 1'b0, j + 8, j + 6));                         // Backward
      emit(encBr(condAl, 1'b0, j + 9, j + 9));                         // Halt loop
      haltAddr = 32'((j + 9) * 4);
   endtask

   // Compare at the falling edge, where all DUT outputs are settled
   always @(negedge clk)
   begin
      if (running)
      begin
         if (stalledPrev)
            expectTrue(pc === lastPc, "pc changed across a stall cycle");
         if (pcReady)
         begin
            compareWord({sectionName(mPc), " pc"}, mPc, pc);
            if (mPc == haltAddr)
               done = 1'b1;
            else
            begin
               modelStep(imem[mPc[9:2]]);
               compareWord({sectionName(pc), " memWrite"}, 32'(mStore), 32'(memWrite));
               compareWord({sectionName(pc), " memStrobe"}, 32'(mAccess), 32'(memStrobe));
               if (mStore)
               begin
                  compareWord({sectionName(pc), " store address"}, mStoreAddr, aluResult);
                  compareWord({sectionName(pc), " store data"}, mStoreData, writeData);
               end
            end
         end
         else
            expectTrue(memWrite === 1'b0, "memWrite high while pcReady is low");
         stalledPrev = !pcReady;
         lastPc = pc;
      end
   end

   initial
   begin
      int seedSink;
      reset   = 1'b1;
      pcReady = 1'b0;
      seedSink = $urandom(32'h7dc4);
      buildProgram();
      for (int i = 0; i < 1024; i++)
         dmem[i] = $urandom;
      dmem[128] = 32'h7fff_ffff;
      dmem[129] = 32'h8000_0000;
      mMem   = dmem;
      mPc    = resetPc;
      mFlags = 4'h0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      running = 1'b1;
      @(negedge clk);
      compareWord("reset pc", resetPc, pc);
      expectTrue(!memWrite && !memStrobe, "memWrite or memStrobe high right after reset");
      while (!done)
      begin
         @(posedge clk);
         pcReady <= ($urandom % 4) != 0;   // Roughly one cycle in four stalls
      end
      @(negedge clk);
      for (int i = 0; i < 1024; i++)
         compareWord($sformatf("final memory word %0d", i), mMem[i], dmem[i]);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // Budget of four cycles per program word covers the random stalls
   initial
   begin
      #1;
      #((progLen * 4 + watchdogMargin) * clkPeriod);
      $display("Timeout, the program never reached its halt loop, %0d errors so far", errors);
      $display("Result: FAILED");
      $finish;
   end

endmodule

/* all.f */
+incdir+.
armIsaPkg.sv
armCtrlPkg.sv
regFile.sv
armAlu.sv
armDecoder.sv
condUnit.sv
armDatapath.sv
armCore.sv
tbArmCore.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbArmCore
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
